//--- source/tscPkg.sv
// Shared widths, ISA encodings and ALU operation codes, imported by every CPU RTL file
`default_nettype none

package tscPkg;

    // Data and address width fixed by the instruction encoding
    parameter int WordWidth = 16;

    typedef logic [WordWidth-1:0] wordT;
    typedef logic [1:0]           regAddrT;

    // Primary opcode in bits 15:12
    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opAdi   = 4'd4,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcodeT;

    // Function field of the register group, bits 5:0
    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOr  = 6'd3,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluPassB,
        aluCmpEq,
        aluCmpNe
    } aluOpT;

    // Register group with an unused function, decodes to nothing
    parameter wordT bubbleInstr = 16'hFFFF;

endpackage

`default_nettype wire

//--- source/pipeIf.sv
// Decoded control bundle from the decode stage into ID/EX, one modport per side
`timescale 1ns/1ps
`default_nettype none

interface pipeIf import tscPkg::*; ();

    aluOpT   aluOp;
    logic    useImm;
    logic    loadHigh;
    logic    memRead;
    logic    memWrite;
    logic    regWrite;
    // High selects load data for write-back
    logic    regSrc;
    regAddrT dest;
    logic    isBranch;
    logic    isOut;
    logic    isHalt;
    // Low marks a bubble
    logic    valid;

    modport ctrl (
        output aluOp, useImm, loadHigh, memRead, memWrite, regWrite,
        output regSrc, dest, isBranch, isOut, isHalt, valid
    );

    modport exec (
        input aluOp, useImm, loadHigh, memRead, memWrite, regWrite,
        input regSrc, dest, isBranch, isOut, isHalt, valid
    );

endinterface

`default_nettype wire

//--- source/pipeCtrl.sv
// Decode stage control: instruction decoder, RAW hazard stall and IF/ID flush, jump resolve
`timescale 1ns/1ps
`default_nettype none

module pipeCtrl import tscPkg::*; (
    input  wire logic    Clk,
    input  wire logic    i_arstN,
    input  wire wordT    i_instr,
    input  wire wordT    i_ifIdPc,
    input  wire regAddrT i_exDest,
    input  wire regAddrT i_memDest,
    input  wire regAddrT i_wbDest,
    input  wire logic    i_exRegWrite,
    input  wire logic    i_memRegWrite,
    input  wire logic    i_wbRegWrite,
    input  wire logic    i_redirect,
    input  wire logic    i_halted,
    output logic         o_pcHold,
    output logic         o_ifIdFlush,
    output logic         o_jumpTaken,
    output wordT         o_jumpPc,
    pipeIf.ctrl          decBus
);

    //////////////////////////////////////////////////////////////////////
    // Field extraction and decode
    //////////////////////////////////////////////////////////////////////

    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    logic    useA;
    logic    useB;
    logic    isJump;
    logic    known;
    logic    hazard;
    logic    stall;

    assign rs = i_instr[11:10];
    assign rt = i_instr[9:8];
    assign rd = i_instr[7:6];

    always_comb begin
        decBus.aluOp    = aluAdd;
        decBus.useImm   = 1'b0;
        decBus.loadHigh = 1'b0;
        decBus.memRead  = 1'b0;
        decBus.memWrite = 1'b0;
        decBus.regWrite = 1'b0;
        decBus.regSrc   = 1'b0;
        decBus.dest     = rt;
        decBus.isBranch = 1'b0;
        decBus.isOut    = 1'b0;
        decBus.isHalt   = 1'b0;
        useA            = 1'b0;
        useB            = 1'b0;
        isJump          = 1'b0;
        known           = 1'b1;
        case (opcodeT'(i_instr[15:12]))
            opBne, opBeq: begin
                // Compare result bit 0 decides taken in execute
                decBus.aluOp    = (i_instr[15:12] == opBeq) ? aluCmpEq : aluCmpNe;
                decBus.isBranch = 1'b1;
                useA            = 1'b1;
                useB            = 1'b1;
            end
            opAdi: begin
                decBus.useImm   = 1'b1;
                decBus.regWrite = 1'b1;
                useA            = 1'b1;
            end
            opLhi: begin
                decBus.aluOp    = aluPassB;
                decBus.useImm   = 1'b1;
                decBus.loadHigh = 1'b1;
                decBus.regWrite = 1'b1;
            end
            opLwd: begin
                decBus.useImm   = 1'b1;
                decBus.memRead  = 1'b1;
                decBus.regWrite = 1'b1;
                decBus.regSrc   = 1'b1;
                useA            = 1'b1;
            end
            opSwd: begin
                // Address from rs, store data from rt
                decBus.useImm   = 1'b1;
                decBus.memWrite = 1'b1;
                useA            = 1'b1;
                useB            = 1'b1;
            end
            opJmp: isJump = 1'b1;
            opRtype: begin
                case (funcT'(i_instr[5:0]))
                    fnAdd, fnSub, fnAnd, fnOr: begin
                        decBus.aluOp    = aluOpT'(i_instr[2:0]);
                        decBus.regWrite = 1'b1;
                        decBus.dest     = rd;
                        useA            = 1'b1;
                        useB            = 1'b1;
                    end
                    fnWwd: begin
                        decBus.isOut = 1'b1;
                        useA         = 1'b1;
                    end
                    fnHlt:   decBus.isHalt = 1'b1;
                    // Bubble and unused functions
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Hazard, stall and flush
    //////////////////////////////////////////////////////////////////////

    // Producer still in EX, MEM or WB, no forwarding
    assign hazard = (useA && ((i_exRegWrite  && i_exDest  == rs) ||
                              (i_memRegWrite && i_memDest == rs) ||
                              (i_wbRegWrite  && i_wbDest  == rs))) ||
                    (useB && ((i_exRegWrite  && i_exDest  == rt) ||
                              (i_memRegWrite && i_memDest == rt) ||
                              (i_wbRegWrite  && i_wbDest  == rt)));

    // Branch redirect flushes decode anyway
    assign stall = hazard && !i_redirect;

    // Branch redirect outranks a jump in decode
    assign o_jumpTaken = isJump && !i_redirect;
    assign o_jumpPc    = {i_ifIdPc[15:12], i_instr[11:0]};

    assign o_pcHold    = stall;
    assign o_ifIdFlush = i_redirect || o_jumpTaken;

    assign decBus.valid = known && !stall && !i_redirect && !i_halted;

    // IF/ID cannot be held and flushed in one cycle
    assert property (@(posedge Clk) disable iff (!i_arstN) !(o_pcHold && o_ifIdFlush));

    // Stalled instruction never enters execute
    assert property (@(posedge Clk) disable iff (!i_arstN) hazard |-> !decBus.valid);

endmodule

`default_nettype wire

//--- source/fetchUnit.sv
// Fetch stage: program counter, next-PC priority and the IF/ID pipeline register
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import tscPkg::*; #(
    parameter wordT ResetPc = '0
) (
    input  wire logic Clk,
    input  wire logic i_arstN,
    input  wire logic i_hold,
    input  wire logic i_halted,
    input  wire logic i_redirect,
    input  wire logic i_jumpTaken,
    input  wire wordT i_redirectPc,
    input  wire wordT i_jumpPc,
    input  wire wordT i_instData,
    input  wire logic i_flushIfId,
    output wordT      o_instAddr,
    output wordT      o_ifIdInstr,
    output wordT      o_ifIdPc
);

    wordT pc;
    wordT nextPc;

    assign o_instAddr = pc;

    // Execute redirect first, then decode jump, else sequential
    always_comb begin
        if (i_redirect) begin
            nextPc = i_redirectPc;
        end else if (i_jumpTaken) begin
            nextPc = i_jumpPc;
        end else begin
            nextPc = pc + WordWidth'(1);
        end
    end

    always_ff @(posedge Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            pc <= ResetPc;
        end else if (!i_hold && !i_halted) begin
            pc <= nextPc;
        end
    end

    // IF/ID starts as a bubble
    always_ff @(posedge Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_ifIdInstr <= bubbleInstr;
            o_ifIdPc    <= '0;
        end else if (!i_halted) begin
            if (i_flushIfId) begin
                o_ifIdInstr <= bubbleInstr;
            end else if (!i_hold) begin
                o_ifIdInstr <= i_instData;
                o_ifIdPc    <= pc;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/regFile.sv
// Four-entry register file, two combinational read ports and one write port at the clock edge
`timescale 1ns/1ps
`default_nettype none

module regFile import tscPkg::*; (
    input  wire logic    Clk,
    input  wire logic    i_arstN,
    input  wire regAddrT i_rdAddrA,
    input  wire regAddrT i_rdAddrB,
    input  wire regAddrT i_wrAddr,
    input  wire logic    i_wrEn,
    input  wire wordT    i_wrData,
    output wordT         o_rdDataA,
    output wordT         o_rdDataB
);

    wordT regs [4];

    // No write-through, a write is seen the cycle after
    assign o_rdDataA = regs[i_rdAddrA];
    assign o_rdDataB = regs[i_rdAddrB];

    always_ff @(posedge Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wrEn) begin
            regs[i_wrAddr] <= i_wrData;
        end
    end

endmodule

`default_nettype wire

//--- source/execStage.sv
// Execute stage: ID/EX register, operand select, ALU, branch resolve, halt flag and EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module execStage import tscPkg::*; (
    input  wire logic Clk,
    input  wire logic i_arstN,
    pipeIf.exec       decBus,
    input  wire wordT i_srcA,
    input  wire wordT i_srcB,
    input  wire wordT i_imm,
    input  wire wordT i_pc,
    output logic      o_redirect,
    output wordT      o_redirectPc,
    output regAddrT   o_exDest,
    output regAddrT   o_memDest,
    output logic      o_exRegWrite,
    output logic      o_memRegWrite,
    output logic      o_outValid,
    output wordT      o_outWord,
    output logic      o_halted,
    output wordT      o_memAluResult,
    output wordT      o_memStoreData,
    output logic      o_memRead,
    output logic      o_memWrite,
    output logic      o_memRegSrc
);

    //////////////////////////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////////////////////////

    logic    idExValid;
    logic    idExRegWrite;
    logic    idExMemRead;
    logic    idExMemWrite;
    logic    idExIsBranch;
    logic    idExIsOut;
    logic    idExIsHalt;
    aluOpT   idExAluOp;
    logic    idExUseImm;
    logic    idExLoadHigh;
    logic    idExRegSrc;
    wordT    srcA;
    wordT    srcB;
    wordT    imm;
    wordT    pc;
    logic    haltNow;
    logic    idExLoad;
    wordT    opB;
    wordT    aluResult;

    assign haltNow  = idExValid && idExIsHalt;
    // HLT stays parked in execute
    assign idExLoad = !o_halted && !haltNow;

    always_ff @(posedge Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            idExValid    <= 1'b0;
            idExRegWrite <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExIsBranch <= 1'b0;
            idExIsOut    <= 1'b0;
            idExIsHalt   <= 1'b0;
        end else if (idExLoad) begin
            // Wrong-path decode slot dies on redirect
            idExValid    <= decBus.valid && !o_redirect;
            idExRegWrite <= decBus.regWrite;
            idExMemRead  <= decBus.memRead;
            idExMemWrite <= decBus.memWrite;
            idExIsBranch <= decBus.isBranch;
            idExIsOut    <= decBus.isOut;
            idExIsHalt   <= decBus.isHalt;
        end
    end

    always_ff @(posedge Clk) begin
        if (idExLoad) begin
            idExAluOp    <= decBus.aluOp;
            idExUseImm   <= decBus.useImm;
            idExLoadHigh <= decBus.loadHigh;
            idExRegSrc   <= decBus.regSrc;
            o_exDest     <= decBus.dest;
            srcA         <= i_srcA;
            srcB         <= i_srcB;
            imm          <= i_imm;
            pc           <= i_pc;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operands, ALU and branch
    //////////////////////////////////////////////////////////////////////

    // LHI puts the immediate byte on top
    assign opB = !idExUseImm ? srcB : idExLoadHigh ? {imm[7:0], 8'h00} : imm;

    always_comb begin
        case (idExAluOp)
            aluAdd:   aluResult = srcA + opB;
            aluSub:   aluResult = srcA - opB;
            aluAnd:   aluResult = srcA & opB;
            aluOr:    aluResult = srcA | opB;
            aluPassB: aluResult = opB;
            aluCmpEq: aluResult = WordWidth'(srcA == opB);
            aluCmpNe: aluResult = WordWidth'(srcA != opB);
            default:  aluResult = '0;
        endcase
    end

    // Predicted not taken, so only a taken branch redirects
    assign o_redirect   = idExValid && idExIsBranch && aluResult[0];
    assign o_redirectPc = pc + WordWidth'(1) + imm;

    assign o_exRegWrite = idExValid && idExRegWrite;

    // WWD shows rs for its one execute cycle
    assign o_outValid = idExValid && idExIsOut;
    assign o_outWord  = srcA;

    // Sticky until reset
    always_ff @(posedge Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_halted <= 1'b0;
        end else if (haltNow) begin
            o_halted <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_memRegWrite <= 1'b0;
            o_memRead     <= 1'b0;
            o_memWrite    <= 1'b0;
        end else begin
            o_memRegWrite <= o_exRegWrite;
            o_memRead     <= idExValid && idExMemRead;
            o_memWrite    <= idExValid && idExMemWrite;
        end
    end

    always_ff @(posedge Clk) begin
        o_memDest      <= o_exDest;
        o_memRegSrc    <= idExRegSrc;
        o_memAluResult <= aluResult;
        o_memStoreData <= srcB;
    end

endmodule

`default_nettype wire

//--- source/memWbStage.sv
// Memory and write-back stages: data port drive from EX/MEM, MEM/WB register and write-back mux
`timescale 1ns/1ps
`default_nettype none

module memWbStage import tscPkg::*; (
    input  wire logic    Clk,
    input  wire logic    i_arstN,
    input  wire wordT    i_aluResult,
    input  wire wordT    i_storeData,
    input  wire logic    i_memRead,
    input  wire logic    i_memWrite,
    input  wire logic    i_regSrc,
    input  wire logic    i_regWrite,
    input  wire regAddrT i_dest,
    input  wire wordT    i_readData,
    output wordT         o_dataAddr,
    output wordT         o_dataWdata,
    output logic         o_dataRead,
    output logic         o_dataWrite,
    output regAddrT      o_wbDest,
    output logic         o_wbRegWrite,
    output wordT         o_wbData
);

    wordT wbLoadData;
    wordT wbAluResult;
    logic wbRegSrc;

    // Single-cycle port, read data returns in the same cycle
    assign o_dataAddr  = i_aluResult;
    assign o_dataWdata = i_storeData;
    assign o_dataRead  = i_memRead;
    assign o_dataWrite = i_memWrite;

    always_ff @(posedge Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_wbRegWrite <= 1'b0;
        end else begin
            o_wbRegWrite <= i_regWrite;
        end
    end

    always_ff @(posedge Clk) begin
        o_wbDest    <= i_dest;
        wbRegSrc    <= i_regSrc;
        wbLoadData  <= i_readData;
        wbAluResult <= i_aluResult;
    end

    // Write-back select
    assign o_wbData = wbRegSrc ? wbLoadData : wbAluResult;

    assert property (@(posedge Clk) disable iff (!i_arstN) !(o_dataRead && o_dataWrite));

endmodule

`default_nettype wire

//--- source/tscCpu.sv
// Top level of the five-stage pipelined CPU, memories and output port attach here
`timescale 1ns/1ps
`default_nettype none

module tscCpu import tscPkg::*; #(
    parameter logic [WordWidth-1:0] ResetPc = '0
) (
    input  wire logic                 Clk,
    input  wire logic                 i_arstN,
    output logic [WordWidth-1:0]      o_instAddr,
    input  wire logic [WordWidth-1:0] i_instData,
    output logic [WordWidth-1:0]      o_dataAddr,
    output logic [WordWidth-1:0]      o_dataWdata,
    input  wire logic [WordWidth-1:0] i_dataRdata,
    output logic                      o_dataRead,
    output logic                      o_dataWrite,
    output logic                      o_outValid,
    output logic [15:0]               o_outPort,
    output logic                      o_halted
);

    //////////////////////////////////////////////////////////////////////
    // Stage-to-stage nets
    //////////////////////////////////////////////////////////////////////

    wordT    ifIdInstr;
    wordT    ifIdPc;
    logic    pcHold;
    logic    ifIdFlush;
    logic    jumpTaken;
    wordT    jumpPc;
    logic    redirect;
    wordT    redirectPc;
    wordT    rdDataA;
    wordT    rdDataB;
    regAddrT exDest;
    regAddrT memDest;
    regAddrT wbDest;
    logic    exRegWrite;
    logic    memRegWrite;
    logic    wbRegWrite;
    wordT    wbData;
    wordT    memAluResult;
    wordT    memStoreData;
    logic    memRead;
    logic    memWrite;
    logic    memRegSrc;

    pipeIf decBus ();

    //////////////////////////////////////////////////////////////////////
    // Instances
    //////////////////////////////////////////////////////////////////////

    pipeCtrl ctrl (
        .Clk           (Clk),
        .i_arstN       (i_arstN),
        .i_instr       (ifIdInstr),
        .i_ifIdPc      (ifIdPc),
        .i_exDest      (exDest),
        .i_memDest     (memDest),
        .i_wbDest      (wbDest),
        .i_exRegWrite  (exRegWrite),
        .i_memRegWrite (memRegWrite),
        .i_wbRegWrite  (wbRegWrite),
        .i_redirect    (redirect),
        .i_halted      (o_halted),
        .o_pcHold      (pcHold),
        .o_ifIdFlush   (ifIdFlush),
        .o_jumpTaken   (jumpTaken),
        .o_jumpPc      (jumpPc),
        .decBus        (decBus.ctrl)
    );

    fetchUnit #(
        .ResetPc (ResetPc)
    ) fetch (
        .Clk          (Clk),
        .i_arstN      (i_arstN),
        .i_hold       (pcHold),
        .i_halted     (o_halted),
        .i_redirect   (redirect),
        .i_jumpTaken  (jumpTaken),
        .i_redirectPc (redirectPc),
        .i_jumpPc     (jumpPc),
        .i_instData   (i_instData),
        .i_flushIfId  (ifIdFlush),
        .o_instAddr   (o_instAddr),
        .o_ifIdInstr  (ifIdInstr),
        .o_ifIdPc     (ifIdPc)
    );

    // rs and rt fields read in decode
    regFile rf (
        .Clk       (Clk),
        .i_arstN   (i_arstN),
        .i_rdAddrA (ifIdInstr[11:10]),
        .i_rdAddrB (ifIdInstr[9:8]),
        .i_wrAddr  (wbDest),
        .i_wrEn    (wbRegWrite),
        .i_wrData  (wbData),
        .o_rdDataA (rdDataA),
        .o_rdDataB (rdDataB)
    );

    execStage exec (
        .Clk            (Clk),
        .i_arstN        (i_arstN),
        .decBus         (decBus.exec),
        .i_srcA         (rdDataA),
        .i_srcB         (rdDataB),
        .i_imm          ({{8{ifIdInstr[7]}}, ifIdInstr[7:0]}),
        .i_pc           (ifIdPc),
        .o_redirect     (redirect),
        .o_redirectPc   (redirectPc),
        .o_exDest       (exDest),
        .o_memDest      (memDest),
        .o_exRegWrite   (exRegWrite),
        .o_memRegWrite  (memRegWrite),
        .o_outValid     (o_outValid),
        .o_outWord      (o_outPort),
        .o_halted       (o_halted),
        .o_memAluResult (memAluResult),
        .o_memStoreData (memStoreData),
        .o_memRead      (memRead),
        .o_memWrite     (memWrite),
        .o_memRegSrc    (memRegSrc)
    );

    memWbStage memWb (
        .Clk          (Clk),
        .i_arstN      (i_arstN),
        .i_aluResult  (memAluResult),
        .i_storeData  (memStoreData),
        .i_memRead    (memRead),
        .i_memWrite   (memWrite),
        .i_regSrc     (memRegSrc),
        .i_regWrite   (memRegWrite),
        .i_dest       (memDest),
        .i_readData   (i_dataRdata),
        .o_dataAddr   (o_dataAddr),
        .o_dataWdata  (o_dataWdata),
        .o_dataRead   (o_dataRead),
        .o_dataWrite  (o_dataWrite),
        .o_wbDest     (wbDest),
        .o_wbRegWrite (wbRegWrite),
        .o_wbData     (wbData)
    );

endmodule

`default_nettype wire

//--- dv/tbTscCpu.sv
// Testbench for the pipelined CPU, runs every program of the case file and checks its WWD output
`timescale 1ns/1ps
`default_nettype none

module tbTscCpu;

    //////////////////////////////////////////////////////////////////////
    // Constants and DUT hookup
    //////////////////////////////////////////////////////////////////////

    localparam int          ClkHalf     = 50;
    localparam int          DriveDelay  = 1;
    localparam int          ResetCycles = 5;
    // Programs live above 0x3000 so the jump keeps nonzero upper PC bits
    localparam logic [15:0] ProgBase    = 16'h3000;
    // Register group, function 29
    localparam logic [15:0] HltWord     = 16'hF01D;

    logic        Clk;
    logic        arstN;
    logic [15:0] instAddr;
    logic [15:0] instData;
    logic [15:0] dataAddr;
    logic [15:0] dataWdata;
    logic [15:0] dataRdata;
    logic        dataRead;
    logic        dataWrite;
    logic        outValid;
    logic [15:0] outPort;
    logic        halted;

    // Case storage, flat word lists with per-case start and count
    logic [15:0] progWords[$];
    logic [15:0] expWords[$];
    int          progStart[$];
    int          progCount[$];
    int          expStart[$];
    int          expCount[$];
    int          curProg = 0;
    int          curExp = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    logic [15:0] instMem [65536];
    logic [15:0] dataMem [65536];

    tscCpu #(
        .ResetPc (ProgBase)
    ) uut (
        .Clk         (Clk),
        .i_arstN     (arstN),
        .o_instAddr  (instAddr),
        .i_instData  (instData),
        .o_dataAddr  (dataAddr),
        .o_dataWdata (dataWdata),
        .i_dataRdata (dataRdata),
        .o_dataRead  (dataRead),
        .o_dataWrite (dataWrite),
        .o_outValid  (outValid),
        .o_outPort   (outPort),
        .o_halted    (halted)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkHalf) Clk = ~Clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////

    // Combinational instruction read
    assign instData  = instMem[instAddr];
    // Read data only while a load is in MEM
    assign dataRdata = dataRead ? dataMem[dataAddr] : 16'h0000;

    // Both address bytes swapped into the pattern
    function automatic logic [15:0] fillWord(input logic [15:0] addr);
        return {addr[7:0], addr[15:8]} ^ 16'hA55A;
    endfunction

    always @(posedge Clk) begin
        if (!arstN) begin
            for (int a = 0; a < 65536; a++) begin
                dataMem[16'(a)] <= fillWord(16'(a));
            end
        end else if (dataWrite) begin
            dataMem[dataAddr] <= dataWdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and checks
    //////////////////////////////////////////////////////////////////////

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("mismatch at %0d ns: %s is %0h, expected %0h",
                                      $time, name, got, exp));
        end
    endtask

    // Nothing may come out of an idle or resetting CPU
    task automatic checkIdle();
        checkValue("o_outValid", 32'(outValid), 0);
        checkValue("o_halted", 32'(halted), 0);
        checkValue("o_dataRead", 32'(dataRead), 0);
        checkValue("o_dataWrite", 32'(dataWrite), 0);
    endtask

    // Run limit from the total program length
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            stopWithFailure($sformatf("timeout: run not finished after %0d cycles",
                                      cycleLimit));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Case file reader
    //////////////////////////////////////////////////////////////////////

    function automatic bit isBlank(input logic [7:0] c);
        return c == " " || c == "\t" || c == "\n" || c == "\r";
    endfunction

    function automatic int hexValue(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return int'(c - "0");
        end else if (c >= "a" && c <= "f") begin
            return int'(c - "a") + 10;
        end else if (c >= "A" && c <= "F") begin
            return int'(c - "A") + 10;
        end
        return -1;
    endfunction

    task automatic closeCase();
        progStart.push_back(progWords.size() - curProg);
        progCount.push_back(curProg);
        expStart.push_back(expWords.size() - curExp);
        expCount.push_back(curExp);
        curProg = 0;
        curExp  = 0;
    endtask

    // Tag word first, then any number of hex words
    task automatic parseLine(input string line);
        string       tag;
        int          pos;
        int          digit;
        int          nDigits;
        logic [15:0] value;
        pos     = 0;
        nDigits = 0;
        value   = '0;
        while (pos < line.len() && !isBlank(line.getc(pos))) begin
            pos++;
        end
        if (pos > 0 && line.getc(0) != "#") begin
            tag = line.substr(0, pos - 1);
            if (tag == "end") begin
                closeCase();
            end else if (tag == "prog" || tag == "out") begin
                for (int i = pos; i <= line.len(); i++) begin
                    digit = (i < line.len()) ? hexValue(line.getc(i)) : -1;
                    if (digit >= 0) begin
                        value   = {value[11:0], 4'(digit)};
                        nDigits = nDigits + 1;
                    end else if (nDigits > 0) begin
                        if (tag == "prog") begin
                            progWords.push_back(value);
                            curProg = curProg + 1;
                        end else begin
                            expWords.push_back(value);
                            curExp = curExp + 1;
                        end
                        value   = '0;
                        nDigits = 0;
                    end
                end
            end else begin
                stopWithFailure($sformatf("case file has an unknown line tag %s", tag));
            end
        end
    endtask

    task automatic readCases();
        int    fd;
        int    code;
        string line;
        fd = $fopen("dv/tscCases.txt", "r");
        if (fd == 0) begin
            stopWithFailure("could not open the case file dv/tscCases.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    parseLine(line);
                end
            end
            $fclose(fd);
            if (curProg != 0 || curExp != 0) begin
                stopWithFailure("the last case in the case file has no end line");
            end else if (progCount.size() == 0) begin
                stopWithFailure("the case file holds no case");
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Case runner
    //////////////////////////////////////////////////////////////////////

    // Unused instruction words halt the CPU
    task automatic loadProgram(input int idx);
        for (int a = 0; a < 65536; a++) begin
            instMem[16'(a)] = HltWord;
        end
        for (int k = 0; k < progCount[idx]; k++) begin
            instMem[ProgBase + 16'(k)] = progWords[progStart[idx] + k];
        end
    endtask

    task automatic runCase(input int idx);
        logic [15:0] got[$];
        bit          seenHalt;
        int          base;
        @(posedge Clk);
        #(DriveDelay);
        arstN = 1'b0;
        loadProgram(idx);
        repeat (ResetCycles) begin
            @(negedge Clk);
            checkIdle();
            @(posedge Clk);
        end
        #(DriveDelay);
        arstN = 1'b1;
        // IF/ID then ID/EX fill before the first instruction executes
        repeat (2) begin
            @(negedge Clk);
            checkIdle();
        end
        seenHalt = 1'b0;
        while (!seenHalt) begin
            @(negedge Clk);
            if (outValid) begin
                got.push_back(outPort);
            end
            seenHalt = halted;
        end
        // Halt is sticky and nothing after HLT comes out
        repeat (4) begin
            @(negedge Clk);
            checkValue("o_halted", 32'(halted), 1);
            checkValue("o_outValid", 32'(outValid), 0);
        end
        base = expStart[idx];
        checkValue($sformatf("output count of case %0d", idx), got.size(), expCount[idx]);
        for (int k = 0; k < expCount[idx]; k++) begin
            checkValue($sformatf("o_outPort word %0d of case %0d", k, idx),
                       32'(got[k]), 32'(expWords[base + k]));
        end
        $display("case %0d done with %0d output words", idx, got.size());
    endtask

    initial begin
        arstN = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            instMem[16'(a)] = HltWord;
        end
        readCases();
        cycleLimit = progWords.size() * 8 + 100;
        for (int idx = 0; idx < progCount.size(); idx++) begin
            runCase(idx);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tscCases.txt
# Each case: prog gives program words loaded from address 0x3000 on, out gives the
# expected WWD words in order, end closes the case. All words are 16-bit hex.

# ALU functions, add-immediate, load-high and back-to-back dependencies
prog 4105 42FD F6C0 FC1C F6C1 FC1C F602 F01C F603 F01C 6112 4534 F41C 46FF F81C F01D
out  0002 0008 0005 FFFD 1234 1233
end

# Store then load from computed addresses, positive and negative offsets
prog 4110 62AB 4A5C 8603 4702 7C01 F01C 8DFF 7601 F81C F01D
out  AB5C 0010
end

# Taken and untaken BEQ and BNE, WWD in the shadow slots, WWD after HLT
prog 4107 4207 1602 F41C F81C 4321 FC1C 0602 F41C 4A01 0602 F81C F41C 1601 F81C F01D F41C
out  0021 0007 0008
end

# Jumps keep the upper PC bits and skip one word each
prog 4111 9004 F41C 4122 F41C 9008 F41C F01D 4501 F41C F01D
out  0011 0012
end

# Nothing after HLT executes
prog 407F F01C F01D F01C 4001 F01C
out  007F
end

# Register-register chain at hazard distances one to three
prog 4101 4202 4303 F600 F340 F481 F9C3 FC1C F81C F01D
out  0007 0003
end

//--- sim.f
source/tscPkg.sv
source/pipeIf.sv
source/pipeCtrl.sv
source/fetchUnit.sv
source/regFile.sv
source/execStage.sv
source/memWbStage.sv
source/tscCpu.sv
dv/tbTscCpu.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tbTscCpu -o simTscCpu

output=$(./obj_dir/simTscCpu || true)
echo "$output"

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
